/* all.f */
+incdir+include
verilog/vga_video_pkg.sv
verilog/vga_bus_pkg.sv
verilog/vga_scan_timer.sv
verilog/vga_dual_port_ram.sv
verilog/vga_apb_regs.sv
verilog/vga_text_render.sv
verilog/vga_text_top.sv
tb/vga_text_tb.sv

/* include/vga_cfg.svh */
`ifndef VGA_CFG_SVH
`define VGA_CFG_SVH

// Horizontal timing in pixels
`define VGA_H_TOTAL     800
`define VGA_H_SYNC      96
`define VGA_H_START     144

// Vertical timing in lines
`define VGA_V_TOTAL     525
`define VGA_V_SYNC      2
`define VGA_V_START     71

// Visible text window and character grid
`define VGA_WIN_W       640
`define VGA_WIN_H       400
`define VGA_COLS        40
`define VGA_ROWS        25
`define VGA_CELLS       1000
`define VGA_FONT_BYTES  2048

// APB address map, byte addresses
`define VGA_ADDR_W      13
`define VGA_TEXT_BASE   'h0000
`define VGA_CTRL_ADDR   'h0400
`define VGA_FONT_BASE   'h1000

`endif

/* run.sh */
#!/usr/bin/env bash
# Build and run the VGA text controller testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ns \
	--top-module vga_text_tb -f all.f -Mdir obj_dir

output="$(./obj_dir/Vvga_text_tb)"
echo "$output"

# Exit status follows the pass line
grep -qx "Testbench passed" <<< "$output"

/* tb/vga_text_tb.sv */
`timescale 1ns/1ns
`include "vga_cfg.svh"

module vga_text_tb;
	import vga_bus_pkg::*;
	import vga_video_pkg::*;

	// Two frames plus the bus traffic
	localparam int FRAME_CLKS = 2 * `VGA_H_TOTAL * `VGA_V_TOTAL;
	localparam int TIMEOUT    = 2 * FRAME_CLKS + 520000;
	localparam int CELL       = 16;
	// Unmapped holes including the end of the text range
	localparam logic [12:0] HOLES [6] = '{13'h03e8, 13'h03ff, 13'h0401, 13'h0500,
		13'h1800, 13'h1fff};

	// Sync pulse events seen on the outputs
	typedef struct packed {
		logic h_rise;
		logic h_per;
		logic v_rise;
		logic v_per;
	} sync_ev_t;

	logic     CLK_50MHZ;
	logic     arst_n;
	apb_req_t apb_req;
	apb_rsp_t apb_rsp;
	rgb_t     rgb;
	logic     hsync, vsync;

	// Shadow copy of the DUT state
	logic [7:0] text_sh [`VGA_CELLS];
	logic [7:0] font_sh [`VGA_FONT_BYTES];
	vga_ctrl_t  ctrl_sh = '0;
	// Register value seen by host reads
	vga_ctrl_t  ctrl_host = '0;
	vga_ctrl_t  pix_ctrl = '0;
	integer     seed;
	int         errors = 0, pixels = 0, xfers = 0, cycles = 0;
	// Expected response of the transfer in flight
	logic [7:0] rd_exp = '0;
	logic       err_exp = 1'b0;
	int         acc_waits = 0;
	logic       acc_end;

	// Screen model three enables behind the timer
	logic     ce = 1'b0, last_h = 1'b1, last_v = 1'b1, pos_ok = 1'b0, pix_chk = 1'b0;
	int       pos_x = 0, pos_y = 0, h_low = 0, v_low = 0, h_per = 0, v_per = 0;
	int       frame_cnt = 0;
	sync_ev_t ev = '0;
	rgb_t     exp_rgb = '0;

	vga_text_top dut_i (.CLK_50MHZ, .arst_n, .apb_req, .apb_rsp, .rgb, .hsync, .vsync);

	initial begin
		CLK_50MHZ = 1'b0;
		forever #10 CLK_50MHZ = ~CLK_50MHZ;
	end

	task automatic flag_mismatch(input string name, input int want, input int got);
		$display("[FAIL] %0t %s expected %0d got %0d", $time, name, want, got);
		errors++;
	endtask

	task automatic print_summary();
		$display("Checked %0d pixels and %0d APB transfers, %0d errors", pixels, xfers, errors);
	endtask

	// 0 text, 1 control, 2 font, 3 unmapped
	function automatic int addr_kind(input logic [12:0] addr);
		int a;
		a = int'(addr);
		if (a < `VGA_TEXT_BASE + `VGA_CELLS) return 0;
		if (a == `VGA_CTRL_ADDR) return 1;
		if (a >= `VGA_FONT_BASE && a < `VGA_FONT_BASE + `VGA_FONT_BYTES) return 2;
		return 3;
	endfunction

	////////////////////////////////////////////////////////////
	// APB master
	////////////////////////////////////////////////////////////

	task automatic apb_xfer(input logic wr, input logic [12:0] addr, input logic [7:0] wdata,
		input logic [7:0] want, input logic want_err);
		int waits;
		rd_exp  = want;
		err_exp = want_err;
		// Setup phase
		@(posedge CLK_50MHZ);
		apb_req <= '{paddr: addr, psel: 1'b1, penable: 1'b0, pwrite: wr, pwdata: wdata};
		@(posedge CLK_50MHZ);
		apb_req.penable <= 1'b1;
		waits = 0;
		do begin
			@(posedge CLK_50MHZ);
			waits++;
		end while (!apb_rsp.pready && waits < 8);
		if (!apb_rsp.pready) begin
			$display("APB transfer to 0x%h never completed", addr);
			errors++;
		end
		apb_req.psel    <= 1'b0;
		apb_req.penable <= 1'b0;
		xfers++;
	endtask

	task automatic write_byte(input logic [12:0] addr, input logic [7:0] data);
		int kind;
		kind = addr_kind(addr);
		apb_xfer(1'b1, addr, data, 8'h00, kind == 3);
		if (kind == 0) text_sh[addr[9:0]] = data;
		if (kind == 2) font_sh[addr[10:0]] = data;
		if (kind == 1) begin
			ctrl_host = vga_ctrl_t'(data[6:0]);
			// Same edge as the DUT register
			ctrl_sh <= ctrl_host;
		end
	endtask

	task automatic read_byte(input logic [12:0] addr);
		int         kind;
		logic [7:0] want;
		kind = addr_kind(addr);
		want = 8'h00;
		if (kind == 0) want = text_sh[addr[9:0]];
		if (kind == 1) want = 8'(ctrl_host);
		if (kind == 2) want = font_sh[addr[10:0]];
		apb_xfer(1'b0, addr, 8'h00, want, kind == 3);
	endtask

	// Access cycles spent without pready
	assign acc_end = apb_req.psel && apb_req.penable && apb_rsp.pready;
	always @(posedge CLK_50MHZ) begin
		cycles <= cycles + 1;
		if (apb_req.psel && apb_req.penable && !apb_rsp.pready) acc_waits <= acc_waits + 1;
		else acc_waits <= 0;
		if (cycles == TIMEOUT) begin
			$display("Run timed out after %0d cycles", cycles);
			print_summary();
			$display("Testbench failed");
			$finish;
		end
	end

	////////////////////////////////////////////////////////////
	// Screen position from the output syncs
	////////////////////////////////////////////////////////////

	always @(posedge CLK_50MHZ or negedge arst_n) begin : screen_model
		logic h_fall, v_fall, ok;
		int   nx, ny, wx, wy, code, glyph;
		rgb_t want;
		if (!arst_n) begin
			ce      <= 1'b0;
			ev      <= '0;
			pix_chk <= 1'b0;
		end else begin
			ce      <= ~ce;
			ev      <= '0;
			pix_chk <= 1'b0;
			if (ce) begin
				// Colours the output register takes on this enable
				pix_ctrl <= ctrl_sh;
			end else begin
				// Outputs stable mid pixel
				h_fall = !hsync && last_h;
				v_fall = h_fall && !vsync && last_v;
				ok     = pos_ok || v_fall;
				nx     = h_fall ? 0 : pos_x + 1;
				ny     = !h_fall ? pos_y : (v_fall ? 0 : pos_y + 1);
				pos_x  <= nx;
				pos_y  <= ny;
				last_h <= hsync;
				last_v <= vsync;
				// Pulse widths and periods
				if (!hsync) h_low <= h_fall ? 1 : h_low + 1;
				if (hsync && !last_h) ev.h_rise <= 1'b1;
				if (h_fall && pos_ok) begin
					ev.h_per <= 1'b1;
					h_per    <= pos_x + 1;
				end
				if (h_fall && !vsync) v_low <= v_fall ? 1 : v_low + 1;
				if (h_fall && vsync && !last_v) ev.v_rise <= 1'b1;
				if (v_fall && pos_ok) begin
					ev.v_per <= 1'b1;
					v_per    <= pos_y + 1;
				end
				if (v_fall) begin
					pos_ok    <= 1'b1;
					frame_cnt <= frame_cnt + 1;
				end
				// Expected colour from shadow text and glyph
				wx   = nx - `VGA_H_START;
				wy   = ny - `VGA_V_START;
				want = '0;
				if (pix_ctrl.enable && wx >= 0 && wx < `VGA_WIN_W && wy >= 0 && wy < `VGA_WIN_H) begin
					code  = int'(text_sh[10'((wy / CELL) * `VGA_COLS + wx / CELL)]);
					glyph = int'(font_sh[11'(code * 8 + (wy % CELL) / 2)]);
					// MSB drawn first and each bit two pixels wide
					want  = ((glyph >> (7 - (wx % CELL) / 2)) & 1) != 0 ? pix_ctrl.fg : pix_ctrl.bg;
				end
				exp_rgb <= want;
				pix_chk <= ok || !pix_ctrl.enable;
				if (ok || !pix_ctrl.enable) pixels <= pixels + 1;
			end
		end
	end

	////////////////////////////////////////////////////////////
	// Checks
	////////////////////////////////////////////////////////////

	a_hsync_width: assert property (@(posedge CLK_50MHZ) disable iff (!arst_n)
		ev.h_rise |-> h_low == `VGA_H_SYNC)
		else flag_mismatch("hsync low width", `VGA_H_SYNC, $sampled(h_low));
	a_hsync_period: assert property (@(posedge CLK_50MHZ) disable iff (!arst_n)
		ev.h_per |-> h_per == `VGA_H_TOTAL)
		else flag_mismatch("hsync period", `VGA_H_TOTAL, $sampled(h_per));
	a_vsync_width: assert property (@(posedge CLK_50MHZ) disable iff (!arst_n)
		ev.v_rise |-> v_low == `VGA_V_SYNC)
		else flag_mismatch("vsync low lines", `VGA_V_SYNC, $sampled(v_low));
	a_vsync_period: assert property (@(posedge CLK_50MHZ) disable iff (!arst_n)
		ev.v_per |-> v_per == `VGA_V_TOTAL)
		else flag_mismatch("vsync period", `VGA_V_TOTAL, $sampled(v_per));
	a_pixel: assert property (@(posedge CLK_50MHZ) disable iff (!arst_n)
		pix_chk |-> rgb == exp_rgb)
		else flag_mismatch("rgb", int'($sampled(exp_rgb)), int'($sampled(rgb)));
	a_read_data: assert property (@(posedge CLK_50MHZ) disable iff (!arst_n)
		acc_end && !apb_req.pwrite && !err_exp |-> apb_rsp.prdata == rd_exp)
		else flag_mismatch("prdata", int'($sampled(rd_exp)), int'($sampled(apb_rsp.prdata)));
	a_slave_error: assert property (@(posedge CLK_50MHZ) disable iff (!arst_n)
		acc_end |-> apb_rsp.pslverr == err_exp)
		else flag_mismatch("pslverr", int'($sampled(err_exp)), int'($sampled(apb_rsp.pslverr)));
	// Writes finish in the first access cycle and reads one later
	a_wait_states: assert property (@(posedge CLK_50MHZ) disable iff (!arst_n)
		acc_end |-> acc_waits == (apb_req.pwrite ? 0 : 1))
		else flag_mismatch("wait states", $sampled(apb_req.pwrite) ? 0 : 1, $sampled(acc_waits));

	initial begin : stimulus
		logic [7:0] data;
		arst_n  = 1'b0;
		apb_req = '0;
		seed    = 32'hf39e7002;
		repeat (16) @(posedge CLK_50MHZ);
		arst_n <= 1'b1;
		repeat (4) @(posedge CLK_50MHZ);
		// Random screen and font
		for (int i = 0; i < `VGA_CELLS; i++) begin
			data = 8'($random(seed));
			write_byte(13'(`VGA_TEXT_BASE + i), data);
		end
		for (int i = 0; i < `VGA_FONT_BYTES; i++) begin
			data = 8'($random(seed));
			write_byte(13'(`VGA_FONT_BASE + i), data);
		end
		// Colours set with the display still off
		write_byte(13'(`VGA_CTRL_ADDR), 8'hda);
		read_byte(13'(`VGA_CTRL_ADDR));
		for (int k = 0; k < 6; k++) begin
			data = 8'($random(seed));
			write_byte(HOLES[k], data);
			read_byte(HOLES[k]);
		end
		// Full readback after the stray writes
		for (int i = 0; i < `VGA_CELLS; i++) read_byte(13'(`VGA_TEXT_BASE + i));
		for (int i = 0; i < `VGA_FONT_BYTES; i++) read_byte(13'(`VGA_FONT_BASE + i));
		// First frame blank and second frame drawn
		wait (frame_cnt == 2);
		write_byte(13'(`VGA_CTRL_ADDR), 8'h63);
		wait (frame_cnt == 3);
		write_byte(13'(`VGA_CTRL_ADDR), 8'h62);
		read_byte(13'(`VGA_CTRL_ADDR));
		repeat (20 * 2 * `VGA_H_TOTAL) @(posedge CLK_50MHZ);
		print_summary();
		if (errors == 0) begin
			$display("Testbench passed");
		end else begin
			$display("Testbench failed");
		end
		$finish;
	end

endmodule

/* verilog/vga_apb_regs.sv */
`timescale 1ns/1ns
`include "vga_cfg.svh"

module vga_apb_regs (
	input  logic                              CLK_50MHZ,
	input  logic                              arst_n,
	input  vga_bus_pkg::apb_req_t             req,
	output vga_bus_pkg::apb_rsp_t             rsp,
	output vga_bus_pkg::mem_wr_t              text_wr,
	output vga_bus_pkg::mem_wr_t              font_wr,
	output logic [vga_bus_pkg::MEM_AW-1:0]    host_addr,
	input  logic [7:0]                        text_rdata,
	input  logic [7:0]                        font_rdata,
	output vga_video_pkg::vga_ctrl_t          ctrl
);
	import vga_bus_pkg::*;
	import vga_video_pkg::*;

	localparam int ADDR_W = `VGA_ADDR_W;
	localparam logic [ADDR_W-1:0] TEXT_END  = ADDR_W'(`VGA_TEXT_BASE + `VGA_CELLS);
	localparam logic [ADDR_W-1:0] CTRL_ADDR = ADDR_W'(`VGA_CTRL_ADDR);
	localparam logic [ADDR_W-1:0] FONT_LO   = ADDR_W'(`VGA_FONT_BASE);
	localparam logic [ADDR_W-1:0] FONT_HI   = ADDR_W'(`VGA_FONT_BASE + `VGA_FONT_BYTES);

	logic hit_text, hit_ctrl, hit_font, hit_none;
	logic access, wr_access, rd_access;
	// Read wait state taken
	logic wait_q;

	////////////////////////////////////////////////////////////
	// Address decode
	////////////////////////////////////////////////////////////

	assign hit_text = (req.paddr < TEXT_END);
	assign hit_ctrl = (req.paddr == CTRL_ADDR);
	assign hit_font = (req.paddr >= FONT_LO) && (req.paddr < FONT_HI);
	assign hit_none = ~(hit_text | hit_ctrl | hit_font);

	// Both bases aligned, low bits are the offset
	assign host_addr = req.paddr[MEM_AW-1:0];

	assign access    = req.psel & req.penable;
	assign wr_access = access & req.pwrite;
	assign rd_access = access & ~req.pwrite;

	// Write strobes, first access cycle only since pready ends it
	assign text_wr = '{addr: host_addr, data: req.pwdata, we: wr_access & hit_text};
	assign font_wr = '{addr: host_addr, data: req.pwdata, we: wr_access & hit_font};

	// One wait state on every read
	always_ff @(posedge CLK_50MHZ or negedge arst_n) begin
		if (!arst_n) begin
			wait_q <= 1'b0;
		end else begin
			wait_q <= rd_access & ~wait_q;
		end
	end

	// Control register
	always_ff @(posedge CLK_50MHZ or negedge arst_n) begin
		if (!arst_n) begin
			ctrl <= '0;
		end else if (wr_access && hit_ctrl) begin
			ctrl <= vga_ctrl_t'(req.pwdata[$bits(vga_ctrl_t)-1:0]);
		end
	end

	// Response, read data muxed by decode
	always_comb begin
		rsp.pready  = wr_access | (rd_access & wait_q);
		rsp.pslverr = rsp.pready & hit_none;
		if (hit_text) begin
			rsp.prdata = text_rdata;
		end else if (hit_font) begin
			rsp.prdata = font_rdata;
		end else if (hit_ctrl) begin
			rsp.prdata = 8'(ctrl);
		end else begin
			rsp.prdata = '0;
		end
	end

	// Access phase always preceded by setup
	a_penable_with_psel: assert property (@(posedge CLK_50MHZ) disable iff (!arst_n)
		req.penable |-> req.psel);
	a_setup_to_access: assert property (@(posedge CLK_50MHZ) disable iff (!arst_n)
		(req.psel && !req.penable) |=> (req.psel && req.penable));

endmodule

/* verilog/vga_bus_pkg.sv */
`include "vga_cfg.svh"

package vga_bus_pkg;

	// Widest memory behind the bus is the font
	localparam int MEM_AW = $clog2(`VGA_FONT_BYTES);

	typedef struct packed {
		logic [`VGA_ADDR_W-1:0] paddr;
		logic                   psel;
		logic                   penable;
		logic                   pwrite;
		logic [7:0]             pwdata;
	} apb_req_t;

	typedef struct packed {
		logic [7:0] prdata;
		logic       pready;
		logic       pslverr;
	} apb_rsp_t;

	// Single byte write port into a memory
	typedef struct packed {
		logic [MEM_AW-1:0] addr;
		logic [7:0]        data;
		logic              we;
	} mem_wr_t;

endpackage

/* verilog/vga_dual_port_ram.sv */
`timescale 1ns/1ns

module vga_dual_port_ram #(
	parameter  int DEPTH = 1000,
	localparam int AW    = $clog2(DEPTH)
) (
	input  logic                  CLK_50MHZ,
	input  vga_bus_pkg::mem_wr_t  wr,
	input  logic [AW-1:0]         host_addr,
	output logic [7:0]            host_data,
	input  logic [AW-1:0]         video_addr,
	output logic [7:0]            video_data
);

	// Byte storage
	logic [7:0] mem [DEPTH];

	////////////////////////////////////////////////////////////
	// Write port, shared with the host side
	////////////////////////////////////////////////////////////

	always_ff @(posedge CLK_50MHZ) begin
		if (wr.we) begin
			mem[wr.addr[AW-1:0]] <= wr.data;
		end
	end

	// Host read, data valid one clock later
	always_ff @(posedge CLK_50MHZ) begin
		host_data <= mem[host_addr];
	end

	// Video read
	// Renderer samples it on the next pixel enable
	always_ff @(posedge CLK_50MHZ) begin
		video_data <= mem[video_addr];
	end

	// Bus decode keeps strobes inside this memory
	a_wr_in_range: assert property (@(posedge CLK_50MHZ)
		wr.we |-> (int'(wr.addr) < DEPTH));

endmodule

/* verilog/vga_scan_timer.sv */
`timescale 1ns/1ns
`include "vga_cfg.svh"

module vga_scan_timer (
	input  logic                     CLK_50MHZ,
	input  logic                     arst_n,
	output logic                     pix_ce,
	output vga_video_pkg::scan_pos_t pos,
	output vga_video_pkg::sync_t     sync
);

	// Counter limits, sized to the position fields
	localparam logic [9:0] H_LAST  = 10'(`VGA_H_TOTAL - 1);
	localparam logic [9:0] V_LAST  = 10'(`VGA_V_TOTAL - 1);
	localparam logic [9:0] H_SYNC  = 10'(`VGA_H_SYNC);
	localparam logic [9:0] V_SYNC  = 10'(`VGA_V_SYNC);
	localparam logic [9:0] H_START = 10'(`VGA_H_START);
	localparam logic [9:0] V_START = 10'(`VGA_V_START);
	localparam logic [9:0] H_END   = 10'(`VGA_H_START + `VGA_WIN_W);
	localparam logic [9:0] V_END   = 10'(`VGA_V_START + `VGA_WIN_H);

	////////////////////////////////////////////////////////////
	// Pixel enable and raster counters
	////////////////////////////////////////////////////////////

	always_ff @(posedge CLK_50MHZ or negedge arst_n) begin
		if (!arst_n) begin
			pix_ce <= 1'b0;
			pos    <= '0;
		end else begin
			// 25 MHz enable, every second clock
			pix_ce <= ~pix_ce;
			if (pix_ce) begin
				if (pos.x == H_LAST) begin
					pos.x <= '0;
					// Line done, step the frame
					if (pos.y == V_LAST) begin
						pos.y <= '0;
					end else begin
						pos.y <= pos.y + 10'd1;
					end
				end else begin
					pos.x <= pos.x + 10'd1;
				end
			end
		end
	end

	// Sync pulses at the start of line and frame
	always_comb begin
		sync.hsync  = (pos.x >= H_SYNC);
		sync.vsync  = (pos.y >= V_SYNC);
		// 640x400 window
		sync.active = (pos.x >= H_START) && (pos.x < H_END) &&
			(pos.y >= V_START) && (pos.y < V_END);
	end

	// Counters never leave the frame
	a_pos_in_frame: assert property (@(posedge CLK_50MHZ) disable iff (!arst_n)
		(pos.x <= H_LAST) && (pos.y <= V_LAST));

endmodule

/* verilog/vga_text_render.sv */
`timescale 1ns/1ns
`include "vga_cfg.svh"

module vga_text_render (
	input  logic                                  CLK_50MHZ,
	input  logic                                  arst_n,
	input  logic                                  pix_ce,
	input  vga_video_pkg::scan_pos_t              pos,
	input  vga_video_pkg::sync_t                  sync,
	input  vga_video_pkg::vga_ctrl_t              ctrl,
	output logic [$clog2(`VGA_CELLS)-1:0]         text_addr,
	input  logic [7:0]                            text_data,
	output logic [$clog2(`VGA_FONT_BYTES)-1:0]    font_addr,
	input  logic [7:0]                            font_data,
	output vga_video_pkg::rgb_t                   rgb,
	output logic                                  hsync,
	output logic                                  vsync
);
	import vga_video_pkg::*;

	localparam logic [9:0] H_START = 10'(`VGA_H_START);
	localparam logic [9:0] V_START = 10'(`VGA_V_START);
	localparam logic [9:0] COLS    = 10'(`VGA_COLS);
	// Idle levels, syncs high and blanked
	localparam sync_t SYNC_IDLE = '{hsync: 1'b1, vsync: 1'b1, active: 1'b0};

	logic [9:0] win_x, win_y;
	logic [9:0] cell_col, cell_row, cell_idx;
	sync_t      s1_sync, s2_sync;
	logic [2:0] s1_glyph_row;
	logic [2:0] s1_bit, s2_bit;
	rgb_t       pix_rgb;

	// Window relative position
	assign win_x = pos.x - H_START;
	assign win_y = pos.y - V_START;

	// 16x16 cells
	assign cell_col = {4'd0, win_x[9:4]};
	assign cell_row = {5'd0, win_y[8:4]};
	// row * 40 + column
	assign cell_idx = cell_row * COLS + cell_col;

	////////////////////////////////////////////////////////////
	// Stage 1 and 2 payload
	////////////////////////////////////////////////////////////

	always_ff @(posedge CLK_50MHZ) begin
		if (pix_ce) begin
			// Stage 1, cell address to text memory
			text_addr    <= sync.active ? cell_idx : '0;
			// Glyph doubled, drop the low bit
			s1_glyph_row <= win_y[3:1];
			s1_bit       <= win_x[3:1];
			// Stage 2, char code arrived, glyph byte address
			font_addr    <= {text_data, s1_glyph_row};
			s2_bit       <= s1_bit;
		end
	end

	// Stage 3 colour select
	always_comb begin
		if (!(s2_sync.active && ctrl.enable)) begin
			pix_rgb = '0;
		end else if (font_data[~s2_bit]) begin
			// MSB is the leftmost pixel
			pix_rgb = ctrl.fg;
		end else begin
			pix_rgb = ctrl.bg;
		end
	end

	////////////////////////////////////////////////////////////
	// Sync delay line and output register
	////////////////////////////////////////////////////////////

	always_ff @(posedge CLK_50MHZ or negedge arst_n) begin
		if (!arst_n) begin
			s1_sync <= SYNC_IDLE;
			s2_sync <= SYNC_IDLE;
			rgb     <= '0;
			hsync   <= 1'b1;
			vsync   <= 1'b1;
		end else if (pix_ce) begin
			s1_sync <= sync;
			s2_sync <= s1_sync;
			// Same depth as colour, stays aligned
			rgb     <= pix_rgb;
			hsync   <= s2_sync.hsync;
			vsync   <= s2_sync.vsync;
		end
	end

endmodule

/* verilog/vga_text_top.sv */
`timescale 1ns/1ns
`include "vga_cfg.svh"

module vga_text_top (
	input  logic                   CLK_50MHZ,
	input  logic                   arst_n,
	input  vga_bus_pkg::apb_req_t  apb_req,
	output vga_bus_pkg::apb_rsp_t  apb_rsp,
	output vga_video_pkg::rgb_t    rgb,
	output logic                   hsync,
	output logic                   vsync
);
	import vga_video_pkg::*;
	import vga_bus_pkg::*;

	localparam int TEXT_AW = $clog2(`VGA_CELLS);
	localparam int FONT_AW = $clog2(`VGA_FONT_BYTES);

	// Timer to renderer
	logic      pix_ce;
	scan_pos_t pos;
	sync_t     sync;
	vga_ctrl_t ctrl;

	// Host side of both memories
	mem_wr_t           text_wr, font_wr;
	logic [MEM_AW-1:0] host_addr;
	logic [7:0]        text_rdata, font_rdata;

	// Video side
	logic [TEXT_AW-1:0] text_vaddr;
	logic [FONT_AW-1:0] font_vaddr;
	logic [7:0]         text_vdata, font_vdata;

	vga_scan_timer timer_i (.CLK_50MHZ, .arst_n, .pix_ce, .pos, .sync);

	vga_apb_regs regs_i (.CLK_50MHZ, .arst_n, .req(apb_req), .rsp(apb_rsp),
		.text_wr, .font_wr, .host_addr, .text_rdata, .font_rdata, .ctrl);

	// One byte per cell
	vga_dual_port_ram #(.DEPTH(`VGA_CELLS)) text_ram_i (.CLK_50MHZ, .wr(text_wr),
		.host_addr(host_addr[TEXT_AW-1:0]), .host_data(text_rdata),
		.video_addr(text_vaddr), .video_data(text_vdata));

	// 256 glyphs, 8 rows each
	vga_dual_port_ram #(.DEPTH(`VGA_FONT_BYTES)) font_ram_i (.CLK_50MHZ, .wr(font_wr),
		.host_addr(host_addr[FONT_AW-1:0]), .host_data(font_rdata),
		.video_addr(font_vaddr), .video_data(font_vdata));

	vga_text_render render_i (.CLK_50MHZ, .arst_n, .pix_ce, .pos, .sync, .ctrl,
		.text_addr(text_vaddr), .text_data(text_vdata),
		.font_addr(font_vaddr), .font_data(font_vdata), .rgb, .hsync, .vsync);

endmodule

/* verilog/vga_video_pkg.sv */
package vga_video_pkg;

	// Raster position, pixel column and line
	typedef struct packed {
		logic [9:0] x;
		logic [9:0] y;
	} scan_pos_t;

	// Sync levels as driven to the monitor, active low pulses
	typedef struct packed {
		logic hsync;
		logic vsync;
		logic active;
	} sync_t;

	// One bit per channel
	typedef struct packed {
		logic r;
		logic g;
		logic b;
	} rgb_t;

	// Control register layout, fg in [6:4], bg in [3:1], enable in [0]
	typedef struct packed {
		rgb_t fg;
		rgb_t bg;
		logic enable;
	} vga_ctrl_t;

endpackage
